/* src.f */
logic/huff_pkg.sv
logic/token_receiver.sv
logic/token_fifo.sv
logic/huff_table_ram.sv
logic/varlen_encode.sv
logic/code_merge.sv
logic/huff_encoder.sv
logic/jpeg_huffman_top.sv
testbench/huff_checker.sv
testbench/huff_tb.sv

/* Makefile */
TOP  := huff_tb
SRCS := $(shell cat src.f)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "TEST OK" sim.log

obj_dir/V$(TOP): src.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f src.f

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* testbench/huff_tb.sv */
// testbench top for the jpeg huffman back end, loads the tables and runs token tests
`timescale 1ns/1ps

module huff_tb;
    import huff_pkg::*;

    localparam int N_ROWS     = 6;
    localparam int MAX_TOK    = 8;
    localparam int ACK_WAIT   = 60;      // room for a full fifo to drain
    localparam int DRAIN_WAIT = 100;
    localparam int FLUSH_WAIT = 30;      // flush follows 10 idle cycles

    logic       xclk;
    logic       rst;
    logic       tok_req;
    tok_u       tok;
    logic       tbl_we;
    logic       tbl_a_not_d;
    logic [7:0] tbl_d;
    logic       tok_ack;
    logic       code_valid;
    code_word_t code;
    logic       flush;

    string       row_name [N_ROWS];
    bit          row_flush [N_ROWS];     // test ends a last block
    int          row_len [N_ROWS];
    tok_u        row_tok [N_ROWS][MAX_TOK];
    int          n_rows;
    logic [15:0] lfsr;
    bit          timed_out;
    int          tb_errs;

    jpeg_huffman_top dut0 (
        .xclk(xclk), .rst(rst), .tok_req(tok_req), .tok(tok),
        .tbl_we(tbl_we), .tbl_a_not_d(tbl_a_not_d), .tbl_d(tbl_d),
        .tok_ack(tok_ack), .code_valid(code_valid), .code(code), .flush(flush)
    );

    huff_checker chk0 (
        .xclk(xclk), .rst(rst), .tok(tok), .tok_ack(tok_ack),
        .tbl_we(tbl_we), .tbl_a_not_d(tbl_a_not_d), .tbl_d(tbl_d),
        .code_valid(code_valid), .code(code), .flush(flush)
    );

    initial begin
        xclk = 1'b0;
        forever #10 xclk = ~xclk;        // 20 ns period
    end

    // galois lfsr, one step per bit taken
    function automatic logic [15:0] next_bits(input int n);
        logic [15:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) lfsr = lfsr ^ 16'hb400;
            r = {r[14:0], b};
        end
        return r;
    endfunction

    function automatic tok_u dc_tok(input logic color, input logic last, input int v);
        tok_u t;
        t = '0;
        t.coef.is_coef = 1'b1;
        t.coef.is_dc   = 1'b1;
        t.coef.color   = color;
        t.coef.last    = last;
        t.coef.value   = 12'(v);
        return t;
    endfunction

    function automatic tok_u ac_tok(input logic last, input int v);
        tok_u t;
        t = dc_tok(1'b0, last, v);
        t.coef.is_dc = 1'b0;
        return t;
    endfunction

    function automatic tok_u run_tok(input int zrl, input int run);
        tok_u t;
        t = '0;
        t.ctrl.zrl_cnt = 2'(zrl);
        t.ctrl.run     = 4'(run);
        return t;
    endfunction

    function automatic tok_u eob_tok();
        tok_u t;
        t = '0;
        t.ctrl.is_eob = 1'b1;
        return t;
    endfunction

    task automatic new_row(input string name, input bit fl);
        row_name[n_rows]  = name;
        row_flush[n_rows] = fl;
        row_len[n_rows]   = 0;
        n_rows++;
    endtask

    task automatic add_token(input tok_u t);
        row_tok[n_rows-1][row_len[n_rows-1]] = t;
        row_len[n_rows-1]++;
    endtask

    task automatic build_rows();
        new_row("dc_colors", 1'b0);
        add_token(dc_tok(1'b0, 1'b0, 0));
        add_token(eob_tok());
        add_token(dc_tok(1'b1, 1'b0, 5));       // chroma half
        add_token(ac_tok(1'b0, -9));
        add_token(eob_tok());
        add_token(dc_tok(1'b0, 1'b0, -300));    // back to luma
        add_token(eob_tok());
        new_row("ac_runs", 1'b0);
        add_token(dc_tok(1'b0, 1'b0, 1));
        add_token(run_tok(0, 5));
        add_token(ac_tok(1'b0, -2));
        add_token(run_tok(0, 15));
        add_token(ac_tok(1'b0, 2047));          // 11-bit magnitude
        add_token(ac_tok(1'b0, -1024));
        add_token(eob_tok());
        new_row("zrl_codes", 1'b0);
        add_token(dc_tok(1'b1, 1'b0, 3));
        add_token(run_tok(1, 2));
        add_token(ac_tok(1'b0, 4));
        add_token(run_tok(3, 15));
        add_token(ac_tok(1'b0, -5));
        add_token(eob_tok());
        new_row("zrl_burst", 1'b0);
        add_token(dc_tok(1'b0, 1'b0, 2));
        for (int i = 0; i < 4; i++) begin
            add_token(run_tok(3, 0));           // three f0 codes each
        end
        add_token(ac_tok(1'b0, 6));
        add_token(eob_tok());
        new_row("last_ac", 1'b1);
        add_token(dc_tok(1'b1, 1'b1, -7));
        add_token(run_tok(0, 1));
        add_token(ac_tok(1'b1, 33));
        new_row("last_eob", 1'b1);
        add_token(dc_tok(1'b0, 1'b1, 64));
        add_token(ac_tok(1'b0, -64));
        add_token(eob_tok());
    endtask

    task automatic send_byte(input logic is_addr, input logic [7:0] d);
        @(posedge xclk);
        tbl_we      <= 1'b1;
        tbl_a_not_d <= is_addr;
        tbl_d       <= d;
    endtask

    // random lengths 1..16, codes masked to their length
    task automatic load_tables();
        tbl_entry_t e;
        int         len;
        for (int a = 0; a < 2**TBL_AW; a++) begin
            if (a % 256 == 0) begin
                send_byte(1'b1, 8'(a));         // pointer, low byte first
                send_byte(1'b1, 8'(a >> 8));
            end
            len           = 1 + int'(next_bits(4));
            e.code_len_m1 = 4'(len - 1);
            e.code        = 16'(32'(next_bits(16)) & ((32'd1 << len) - 32'd1));
            send_byte(1'b0, e.code[7:0]);
            send_byte(1'b0, e.code[15:8]);
            send_byte(1'b0, {4'h0, e.code_len_m1});
        end
        @(posedge xclk);
        tbl_we <= 1'b0;
    endtask

    // four-phase handshake, req up, ack up, req down, ack down
    task automatic send_token(input tok_u t, input string name);
        int n;
        @(posedge xclk);
        tok     <= t;
        tok_req <= 1'b1;
        n = 0;
        while (!tok_ack && n < ACK_WAIT) begin
            @(posedge xclk);
            n++;
        end
        tok_req <= 1'b0;
        if (!tok_ack) begin
            $display("timeout: tok_ack never rose for token %h in %s", t, name);
            timed_out = 1'b1;
            return;
        end
        n = 0;
        while (tok_ack && n < ACK_WAIT) begin
            @(posedge xclk);
            n++;
        end
        if (tok_ack) begin
            $display("timeout: tok_ack stayed high after tok_req fell in %s", name);
            timed_out = 1'b1;
        end
    endtask

    task automatic run_row(input int r);
        int codes0;
        int errs0;
        int flush0;
        int row_errs;
        int n;
        codes0        = chk0.checked;
        errs0         = chk0.errors;
        flush0        = chk0.flushes;
        row_errs      = 0;
        chk0.cur_name = row_name[r];
        for (int i = 0; i < row_len[r] && !timed_out; i++) begin
            send_token(row_tok[r][i], row_name[r]);
        end
        n = 0;
        while (!timed_out && chk0.pending != 0 && n < DRAIN_WAIT) begin
            @(posedge xclk);
            n++;
        end
        if (!timed_out && chk0.pending != 0) begin
            $display("timeout: %0d code words of %s never came out", chk0.pending, row_name[r]);
            timed_out = 1'b1;
        end
        n = 0;
        while (!timed_out && chk0.flushes == flush0 && n < FLUSH_WAIT) begin
            @(posedge xclk);
            n++;
        end
        if (!timed_out && row_flush[r] && chk0.flushes == flush0) begin
            $display("test %s: no flush pulse within %0d cycles", row_name[r], FLUSH_WAIT);
            row_errs++;
        end else if (!timed_out && !row_flush[r] && chk0.flushes != flush0) begin
            $display("test %s: flush pulse in a test with no last block", row_name[r]);
            row_errs++;
        end
        tb_errs += row_errs;
        $display("test %s: %0d codes checked, %0d errors", row_name[r],
                 chk0.checked - codes0, row_errs + chk0.errors - errs0);
    endtask

    initial begin
        rst         = 1'b1;
        tok_req     = 1'b0;
        tok         = '0;
        tbl_we      = 1'b0;
        tbl_a_not_d = 1'b0;
        tbl_d       = '0;
        lfsr        = 16'd38383;
        timed_out   = 1'b0;
        tb_errs     = 0;
        n_rows      = 0;
        build_rows();
        repeat (16) @(posedge xclk);
        rst <= 1'b0;
        @(posedge xclk);
        if (tok_ack || code_valid || flush) begin
            $display("outputs not idle after reset");
            tb_errs++;
        end
        load_tables();
        for (int r = 0; r < n_rows && !timed_out; r++) begin
            run_row(r);
        end
        $display("summary: %0d tests, %0d codes checked, %0d errors",
                 n_rows, chk0.checked, chk0.errors + tb_errs);
        if (timed_out || tb_errs != 0 || chk0.errors != 0) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST OK");
        end
        $finish;
    end

endmodule

/* testbench/huff_checker.sv */
// testbench checker, mirrors the huffman tables and models the encoder output stream
`timescale 1ns/1ps

module huff_checker (
    input  logic                 xclk,
    input  logic                 rst,
    input  huff_pkg::tok_u       tok,
    input  logic                 tok_ack,
    input  logic                 tbl_we,
    input  logic                 tbl_a_not_d,
    input  logic [7:0]           tbl_d,
    input  logic                 code_valid,
    input  huff_pkg::code_word_t code,
    input  logic                 flush
);
    import huff_pkg::*;

    tbl_entry_t        tbl [2**TBL_AW];     // mirror of the dut table
    logic [TBL_AW-1:0] wptr;
    logic              a_hi;                // next address byte is the high one
    int                d_idx;               // data byte within an entry
    logic [15:0]       code_lo;
    code_word_t        exp_q [$];           // words still due, in token order
    logic              ack_q;
    logic              color;               // block color from the last dc
    logic [3:0]        run;                 // pending zero run for the next ac
    logic              last_blk;
    logic              flush_due;           // last word of the last block queued
    int                n_err = 0;
    int                n_chk = 0;
    int                n_flush = 0;
    string             cur_name = "reset";  // test label, written by huff_tb
    int                pending = 0;         // copies below change only on NBA
    int                checked = 0;
    int                errors = 0;
    int                flushes = 0;

    // jpeg size category, bits needed for the magnitude
    function automatic int size_of(input int v);
        int mag;
        int s;
        mag = (v < 0) ? -v : v;
        s = 0;
        while ((1 << s) <= mag) s++;
        return s;
    endfunction

    // negative values send v-1 in size bits
    function automatic int lit_of(input int v, input int s);
        return (v >= 0) ? v : v + (1 << s) - 1;
    endfunction

    task automatic expect_code(input logic [TBL_AW-1:0] addr, input int s, input int lit);
        code_word_t w;
        int         clen;
        longint     acc;
        clen   = int'(tbl[addr].code_len_m1) + 1;
        acc    = longint'(tbl[addr].code) << (CODE_W - clen);   // code at the top
        acc    = acc | (longint'(lit) << (CODE_W - clen - s)); // literal under it
        w.bits = CODE_W'(acc);
        w.len  = CODE_LEN_W'(clen + s);
        exp_q.push_back(w);
    endtask

    task automatic mirror_byte(input logic is_addr, input logic [7:0] d);
        if (is_addr) begin
            if (!a_hi) wptr[7:0] = d;       // low byte first
            else wptr[8] = d[0];
            a_hi  = !a_hi;
            d_idx = 0;
        end else begin
            a_hi = 1'b0;
            if (d_idx == 0) code_lo[7:0] = d;
            else if (d_idx == 1) code_lo[15:8] = d;
            else tbl[wptr] = tbl_entry_t'({d[3:0], code_lo});
            if (d_idx == 2) wptr = wptr + 1'b1;
            d_idx = (d_idx == 2) ? 0 : d_idx + 1;
        end
    endtask

    // one accepted token into its expected code words
    task automatic expand(input tok_u t);
        int v;
        int s;
        v = int'($signed(t.coef.value));
        s = size_of(v);
        if (t.coef.is_coef && t.coef.is_dc) begin
            color = t.coef.color;
            if (t.coef.last) last_blk = 1'b1;
            expect_code({color, 4'(s), 4'hf}, s, lit_of(v, s));
            run = '0;
        end else if (t.coef.is_coef) begin
            expect_code({color, run, 4'(s)}, s, lit_of(v, s));
            if (t.coef.last && last_blk) flush_due = 1'b1;
            run = '0;
        end else if (t.ctrl.is_eob) begin
            expect_code({color, EOB_SYM}, 0, 0);
            if (last_blk) flush_due = 1'b1;
            run = '0;
        end else begin
            for (int i = 0; i < int'(t.ctrl.zrl_cnt); i++) begin
                expect_code({color, ZRL_SYM}, 0, 0);   // no literal on f0
            end
            run = t.ctrl.run;
        end
    endtask

    task automatic check_code();
        code_word_t want;
        if (exp_q.size() == 0) begin
            $display("test %s: code word %h/%0d came with none expected",
                     cur_name, code.bits, code.len);
            n_err++;
        end else begin
            want = exp_q.pop_front();
            n_chk++;
            if (code !== want) begin
                $display("Mismatch in %s: expected %h/%0d, actual %h/%0d",
                         cur_name, want.bits, want.len, code.bits, code.len);
                n_err++;
            end
        end
    endtask

    task automatic check_flush();
        if (!flush_due) begin
            $display("test %s: flush pulse before the last block ended", cur_name);
            n_err++;
        end else if (exp_q.size() != 0) begin
            $display("test %s: flush pulse with %0d code words still due",
                     cur_name, exp_q.size());
            n_err++;
        end
        n_flush++;
        last_blk  = 1'b0;                   // flush closes the frame
        flush_due = 1'b0;
    endtask

    always @(posedge xclk) begin
        if (rst) begin
            wptr      = '0;
            a_hi      = 1'b0;
            d_idx     = 0;
            ack_q     = 1'b0;
            color     = 1'b0;
            run       = '0;
            last_blk  = 1'b0;
            flush_due = 1'b0;
        end else begin
            if (tbl_we) mirror_byte(tbl_a_not_d, tbl_d);
            if (tok_ack && !ack_q) expand(tok);   // token taken at ack rise
            ack_q = tok_ack;
            if (code_valid) check_code();
            if (flush) check_flush();
        end
        pending <= exp_q.size();
        checked <= n_chk;
        errors  <= n_err;
        flushes <= n_flush;
    end

endmodule

/* logic/jpeg_huffman_top.sv */
// jpeg huffman back end top, token handshake, fifo, table ram and encoder
`timescale 1ns/1ps

module jpeg_huffman_top (
    input  logic                 xclk,
    input  logic                 rst,
    input  logic                 tok_req,
    input  huff_pkg::tok_u       tok,
    input  logic                 tbl_we,
    input  logic                 tbl_a_not_d,
    input  logic [7:0]           tbl_d,
    output logic                 tok_ack,
    output logic                 code_valid,
    output huff_pkg::code_word_t code,
    output logic                 flush
);
    import huff_pkg::*;

    logic              push;
    tok_u              push_tok;
    logic              full;
    logic              pop;
    tok_u              head_tok;
    logic              nempty;
    logic [TBL_AW-1:0] rd_addr;
    logic              rd_en;
    tbl_entry_t        rd_data;

    token_receiver rx0 (
        .xclk     (xclk),
        .rst      (rst),
        .tok_req  (tok_req),
        .tok      (tok),
        .full     (full),
        .tok_ack  (tok_ack),
        .push     (push),
        .push_tok (push_tok)
    );

    token_fifo fifo0 (
        .xclk     (xclk),
        .rst      (rst),
        .push     (push),
        .push_tok (push_tok),
        .pop      (pop),
        .head_tok (head_tok),
        .nempty   (nempty),
        .full     (full)
    );

    huff_table_ram tbl0 (
        .xclk        (xclk),
        .rst         (rst),
        .tbl_we      (tbl_we),
        .tbl_a_not_d (tbl_a_not_d),
        .tbl_d       (tbl_d),
        .rd_addr     (rd_addr),
        .rd_en       (rd_en),
        .rd_data     (rd_data)
    );

    huff_encoder enc0 (
        .xclk       (xclk),
        .rst        (rst),
        .head_tok   (head_tok),
        .nempty     (nempty),
        .rd_data    (rd_data),
        .pop        (pop),
        .rd_addr    (rd_addr),
        .rd_en      (rd_en),
        .code_valid (code_valid),
        .code       (code),
        .flush      (flush)
    );

endmodule

/* logic/huff_encoder.sv */
// huffman encoder, decodes tokens into table lookups and merges codes with literals
`timescale 1ns/1ps

module huff_encoder (
    input  logic                        xclk,
    input  logic                        rst,
    input  huff_pkg::tok_u              head_tok,
    input  logic                        nempty,
    input  huff_pkg::tbl_entry_t        rd_data,
    output logic                        pop,
    output logic [huff_pkg::TBL_AW-1:0] rd_addr,
    output logic                        rd_en,
    output logic                        code_valid,
    output huff_pkg::code_word_t        code,
    output logic                        flush
);
    import huff_pkg::*;

    logic              tok_coef;
    logic              e0_dc;          // stage 0, one lookup per event
    logic              e0_ac;
    logic              e0_eob;
    logic              e0_ctl;         // run/zrl word, no lookup itself
    logic              e0_zrl;
    logic              last_word;
    logic [1:0]        zrl_left;       // f0 codes still to issue
    logic [3:0]        run_r;          // run for the next ac
    logic              color_r;        // block color from dc
    logic              s1_dc, s1_ac, s1_eob, s1_zrl;
    logic              s2_dc, s2_ac, s2_eob, s2_zrl;
    logic              s1_color;
    logic              s2_color;
    logic [3:0]        s1_run;
    logic [3:0]        s2_run;
    logic signed [11:0] s1_value;
    logic [3:0]        size;           // valid in stage 2
    logic [10:0]       literal;
    logic [7:0]        sym;
    logic [3:0]        len_dly [3];    // matches ram read latency
    logic [10:0]       lit_dly [3];
    logic [1:0]        vld_dly;
    logic              last_blk;
    logic              flush_rdy;
    logic [3:0]        idle_cnt;

    assign pop       = nempty && (zrl_left == 2'd0);   // stall while f0s go out
    assign tok_coef  = head_tok.coef.is_coef;
    assign e0_dc     = pop && tok_coef && head_tok.coef.is_dc;
    assign e0_ac     = pop && tok_coef && !head_tok.coef.is_dc;
    assign e0_eob    = pop && !tok_coef && head_tok.ctrl.is_eob;
    assign e0_ctl    = pop && !tok_coef && !head_tok.ctrl.is_eob;
    assign e0_zrl    = (zrl_left != 2'd0);
    assign last_word = (e0_ac && head_tok.coef.last) || e0_eob;

    always_ff @(posedge xclk) begin
        if (rst) begin
            zrl_left <= '0;
            run_r    <= '0;
            color_r  <= 1'b0;
        end else begin
            if (e0_ctl)        zrl_left <= head_tok.ctrl.zrl_cnt;
            else if (e0_zrl)   zrl_left <= zrl_left - 2'd1;
            if (e0_ctl)        run_r <= head_tok.ctrl.run;
            else if (pop)      run_r <= '0;              // consumed by ac
            if (e0_dc)         color_r <= head_tok.coef.color;
        end
    end

    // event flags through stages 1 and 2
    always_ff @(posedge xclk) begin
        if (rst) begin
            {s1_dc, s1_ac, s1_eob, s1_zrl} <= '0;
            {s2_dc, s2_ac, s2_eob, s2_zrl} <= '0;
            rd_en <= 1'b0;
        end else begin
            {s1_dc, s1_ac, s1_eob, s1_zrl} <= {e0_dc, e0_ac, e0_eob, e0_zrl};
            {s2_dc, s2_ac, s2_eob, s2_zrl} <= {s1_dc, s1_ac, s1_eob, s1_zrl};
            rd_en <= s2_dc || s2_ac || s2_eob || s2_zrl;
        end
    end

    always_ff @(posedge xclk) begin
        s1_value <= head_tok.coef.value;
        s1_run   <= run_r;
        s1_color <= e0_dc ? head_tok.coef.color : color_r;   // new block color at once
        s2_run   <= s1_run;
        s2_color <= s1_color;
    end

    varlen_encode vle0 (
        .xclk    (xclk),
        .value   (s1_value),
        .size    (size),
        .literal (literal)
    );

    always_comb begin
        sym = EOB_SYM;
        if (s2_zrl)     sym = ZRL_SYM;
        else if (s2_dc) sym = {size, 4'hf};
        else if (s2_ac) sym = {s2_run, size};
    end

    always_ff @(posedge xclk) begin
        rd_addr    <= {s2_color, sym};
        len_dly[0] <= (s2_dc || s2_ac) ? size : 4'd0;      // eob/zrl carry no literal
        lit_dly[0] <= (s2_dc || s2_ac) ? literal : 11'd0;
        for (int i = 1; i < 3; i++) begin
            len_dly[i] <= len_dly[i-1];
            lit_dly[i] <= lit_dly[i-1];
        end
    end

    always_ff @(posedge xclk) begin
        if (rst) vld_dly <= '0;
        else     vld_dly <= {vld_dly[0], rd_en};          // rd_data two cycles on
    end

    code_merge merge0 (
        .xclk       (xclk),
        .rst        (rst),
        .in_valid   (vld_dly[1]),
        .entry      (rd_data),
        .literal    (lit_dly[2]),
        .lit_len    (len_dly[2]),
        .code_valid (code_valid),
        .code       (code)
    );

    // last block tracking and flush timing
    always_ff @(posedge xclk) begin
        if (rst || flush) begin
            last_blk  <= 1'b0;
            flush_rdy <= 1'b0;
        end else begin
            if (e0_dc && head_tok.coef.last) last_blk  <= 1'b1;
            if (last_blk && last_word)       flush_rdy <= 1'b1;
        end
        if (rst)                 idle_cnt <= '0;
        else if (pop || e0_zrl)  idle_cnt <= 4'(FLUSH_IDLE - 1);
        else if (idle_cnt != '0) idle_cnt <= idle_cnt - 4'd1;
        if (rst) flush <= 1'b0;
        else     flush <= flush_rdy && (idle_cnt == '0) && !pop && !flush;
    end

    a_pop_nempty: assert property (
        @(posedge xclk) disable iff (rst) pop |-> nempty
    );

endmodule

/* logic/code_merge.sv */
// joins a huffman code and its literal into one msb-aligned code word with length
`timescale 1ns/1ps

module code_merge (
    input  logic                 xclk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  huff_pkg::tbl_entry_t entry,
    input  logic [10:0]          literal,   // zero when lit_len is zero
    input  logic [3:0]           lit_len,
    output logic                 code_valid,
    output huff_pkg::code_word_t code
);
    import huff_pkg::*;

    logic [CODE_LEN_W-1:0] code_len;
    logic [CODE_W-1:0]     code_al;
    logic [CODE_W-1:0]     lit_al;

    assign code_len = {1'b0, entry.code_len_m1} + CODE_LEN_W'(1);  // 1..16
    // code top-aligned, literal right under it
    assign code_al  = CODE_W'(entry.code) << (CODE_LEN_W'(CODE_W) - code_len);
    assign lit_al   = CODE_W'(literal)
                      << (CODE_LEN_W'(CODE_W) - code_len - CODE_LEN_W'(lit_len));

    always_ff @(posedge xclk) begin
        if (rst) code_valid <= 1'b0;
        else     code_valid <= in_valid;
    end

    always_ff @(posedge xclk) begin
        if (in_valid) begin
            code.bits <= code_al | lit_al;
            code.len  <= code_len + CODE_LEN_W'(lit_len);
        end
    end

    // table lengths plus literal sizes must fit the word
    a_len_fits: assert property (
        @(posedge xclk) disable iff (rst) in_valid |=> code.len <= CODE_W
    );

endmodule

/* logic/varlen_encode.sv */
// jpeg size category and literal bits of a signed 12-bit value, one register stage
`timescale 1ns/1ps

module varlen_encode (
    input  logic              xclk,
    input  logic signed [11:0] value,
    output logic [3:0]        size,      // 0 for zero
    output logic [10:0]       literal    // low size bits, lsb aligned
);

    logic [11:0] mag;
    logic [3:0]  size_c;
    logic [11:0] mask;
    logic [11:0] adj;

    // highest set bit of the magnitude
    always_comb begin
        mag    = value[11] ? 12'(-value) : 12'(value);
        size_c = '0;
        for (int i = 0; i < 12; i++) begin
            if (mag[i]) size_c = 4'(i + 1);
        end
    end

    assign mask = (12'd1 << size_c) - 12'd1;
    assign adj  = value[11] ? 12'(value - 12'sd1) : 12'(value); // ones complement form

    always_ff @(posedge xclk) begin
        size    <= size_c;
        literal <= 11'(adj & mask);
    end

endmodule

/* logic/huff_table_ram.sv */
// huffman table ram, loaded over the byte-serial port, two-stage registered read
`timescale 1ns/1ps

module huff_table_ram (
    input  logic                        xclk,
    input  logic                        rst,
    input  logic                        tbl_we,       // byte strobe
    input  logic                        tbl_a_not_d,  // address byte when high
    input  logic [7:0]                  tbl_d,
    input  logic [huff_pkg::TBL_AW-1:0] rd_addr,
    input  logic                        rd_en,
    output huff_pkg::tbl_entry_t        rd_data       // two cycles after rd_en
);
    import huff_pkg::*;

    tbl_entry_t        mem [2**TBL_AW];
    logic [TBL_AW-1:0] wr_ptr;
    logic              a_phase;     // next address byte is the high one
    logic [1:0]        d_phase;     // data byte index within an entry
    logic [15:0]       d_lo;        // code bytes held until the third byte
    logic              wr_en;
    tbl_entry_t        ram_q;
    logic              rd_en_d;

    assign wr_en = tbl_we && !tbl_a_not_d && (d_phase == 2'd2);

    always_ff @(posedge xclk) begin
        if (rst) begin
            wr_ptr  <= '0;
            a_phase <= 1'b0;
            d_phase <= '0;
        end else if (tbl_we) begin
            if (tbl_a_not_d) begin
                a_phase <= !a_phase;
                d_phase <= '0;                              // realign data bytes
                if (!a_phase) wr_ptr[7:0] <= tbl_d;         // low byte first
                else          wr_ptr[TBL_AW-1:8] <= tbl_d[TBL_AW-9:0];
            end else begin
                a_phase <= 1'b0;
                d_phase <= wr_en ? 2'd0 : d_phase + 2'd1;
                if (wr_en) wr_ptr <= wr_ptr + 1'b1;         // auto increment
            end
        end
    end

    always_ff @(posedge xclk) begin
        if (tbl_we && !tbl_a_not_d) begin
            if (d_phase == 2'd0) d_lo[7:0]  <= tbl_d;       // code low
            if (d_phase == 2'd1) d_lo[15:8] <= tbl_d;       // code high
        end
        if (wr_en) mem[wr_ptr] <= tbl_entry_t'({tbl_d[3:0], d_lo}); // len-1 in low nibble
    end

    // read side, ram register then output register
    always_ff @(posedge xclk) begin
        if (rst) rd_en_d <= 1'b0;
        else     rd_en_d <= rd_en;
    end

    always_ff @(posedge xclk) begin
        if (rd_en)   ram_q   <= mem[rd_addr];
        if (rd_en_d) rd_data <= ram_q;
    end

endmodule

/* logic/token_fifo.sv */
// small synchronous token fifo between the receiver and the huffman encoder
`timescale 1ns/1ps

module token_fifo (
    input  logic           xclk,
    input  logic           rst,
    input  logic           push,
    input  huff_pkg::tok_u push_tok,
    input  logic           pop,        // removes head at this edge
    output huff_pkg::tok_u head_tok,
    output logic           nempty,
    output logic           full
);
    import huff_pkg::*;

    logic [TOK_W-1:0]   mem [FIFO_DEPTH];   // raw token words
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;              // 0..FIFO_DEPTH

    assign head_tok = tok_u'(mem[rd_ptr]);  // show-ahead
    assign nempty   = |count;
    assign full     = count[FIFO_AW];       // msb only set at depth

    always_ff @(posedge xclk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;   // wraps naturally
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;         // both or neither
            endcase
        end
    end

    always_ff @(posedge xclk) begin
        if (push) mem[wr_ptr] <= push_tok;
    end

    a_no_overflow: assert property (
        @(posedge xclk) disable iff (rst) push |-> !full
    );

    a_no_underflow: assert property (
        @(posedge xclk) disable iff (rst) pop |-> nempty
    );

endmodule

/* logic/token_receiver.sv */
// four-phase req/ack slave that captures run-length tokens into the token fifo
`timescale 1ns/1ps

module token_receiver (
    input  logic           xclk,
    input  logic           rst,
    input  logic           tok_req,     // source holds tok while high
    input  huff_pkg::tok_u tok,
    input  logic           full,        // fifo has no room
    output logic           tok_ack,
    output logic           push,        // one cycle per request
    output huff_pkg::tok_u push_tok
);

    // tok_ack doubles as the fsm state, low = idle, high = acked
    always_ff @(posedge xclk) begin
        if (rst) begin
            tok_ack <= 1'b0;
            push    <= 1'b0;
        end else begin
            push <= 1'b0;                            // single cycle strobe
            if (!tok_ack) begin
                if (push) begin
                    tok_ack <= 1'b1;                 // token written last edge
                end else if (tok_req && !full) begin
                    push <= 1'b1;                    // room, take it
                end
            end else if (!tok_req) begin
                tok_ack <= 1'b0;                     // source released
            end
        end
    end

    // capture alongside the push decision
    always_ff @(posedge xclk) begin
        if (!tok_ack && !push && tok_req) begin
            push_tok <= tok;
        end
    end

    // source keeps the token steady until it sees ack
    a_tok_stable: assert property (
        @(posedge xclk) disable iff (rst)
        (tok_req && !tok_ack) ##1 (tok_req && !tok_ack) |-> $stable(tok)
    );

endmodule

/* logic/huff_pkg.sv */
// shared constants, token union and table/code word types for the huffman back end
package huff_pkg;

    localparam int TOK_W      = 16;              // run-length token word
    localparam int FIFO_DEPTH = 4;               // token fifo entries, power of two
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
    localparam int TBL_AW     = 9;               // msb picks luma/chroma half
    localparam int CODE_W     = 27;              // msb-aligned output word
    localparam int CODE_LEN_W = 5;
    localparam int FLUSH_IDLE = 10;              // quiet cycles before flush

    localparam logic [7:0] ZRL_SYM = 8'hf0;      // sixteen zeros
    localparam logic [7:0] EOB_SYM = 8'h00;      // end of block

    // coefficient view of a token
    typedef struct packed {
        logic        is_coef;                    // set for dc/ac
        logic        is_dc;
        logic        color;                      // dc only, held for the block
        logic        last;                       // dc: last block, ac: last word
        logic [11:0] value;                      // two's complement
    } coef_t;

    // control view, zero runs and end of block
    typedef struct packed {
        logic        is_coef;                    // clear here
        logic [1:0]  pad_hi;
        logic        is_eob;                     // also ends the last block
        logic [5:0]  pad_lo;
        logic [1:0]  zrl_cnt;                    // f0 codes sent ahead
        logic [3:0]  run;                        // zeros before next ac
    } ctrl_t;

    typedef union packed {
        coef_t coef;
        ctrl_t ctrl;
    } tok_u;

    // one table entry, 20 bits
    typedef struct packed {
        logic [3:0]  code_len_m1;                // length minus one
        logic [15:0] code;                       // lsb aligned
    } tbl_entry_t;

    typedef struct packed {
        logic [CODE_W-1:0]     bits;             // code then literal, msb first
        logic [CODE_LEN_W-1:0] len;              // total valid bits
    } code_word_t;

endpackage
